/* vlog.f */
spw_rx_pkg.sv
ds_char_framer.sv
char_fifo.sv
token_decoder.sv
spw_rx_top.sv
spw_rx_properties.sv
tb_spw_rx.sv

/* Makefile */
TOP := tb_spw_rx

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tb_spw_rx.sv */
`default_nettype none

module tb_spw_rx;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum {K_DATA, K_FCT, K_EOP, K_EEP, K_ESC} kind_e;
	typedef enum {T_NONE, T_FCT, T_NULL, T_NCHAR, T_TIME, T_ESCERR} tok_e;

	typedef struct {
		kind_e      kind;
		logic [7:0] payload;
		logic       bad;
		tok_e       tok;
		logic [8:0] val;
	} row_t;

	localparam int NUM_ROWS    = 25;
	localparam int RAND_FIRST  = 15;
	localparam int NUM_RANDOM  = 8;
	localparam int BIT_CLOCKS  = 4;
	localparam int CYCLE_LIMIT = NUM_ROWS * 10 * BIT_CLOCKS + 200;

	logic       negedge_clk = 1'b0;
	logic       rx_resetn;
	logic       rx_din;
	logic       rx_sin;
	logic       got_fct;
	logic       got_null;
	logic       got_nchar;
	logic [8:0] nchar_data;
	logic       got_time_code;
	logic [7:0] time_code;
	logic       parity_error;
	logic       esc_error;
	logic       fifo_overflow;

	// ------------------------------------------------------------------------
	// Stimulus table of kind, payload, bad parity, expected token and value
	// ------------------------------------------------------------------------
	row_t rows [NUM_ROWS] = '{
		'{K_FCT,  8'h00, 1'b0, T_FCT,    9'h000},
		'{K_ESC,  8'h00, 1'b0, T_NONE,   9'h000},
		'{K_FCT,  8'h00, 1'b0, T_NULL,   9'h000},
		'{K_ESC,  8'h00, 1'b0, T_NONE,   9'h000},
		'{K_FCT,  8'h00, 1'b0, T_NULL,   9'h000},
		'{K_DATA, 8'h5a, 1'b0, T_NCHAR,  9'h05a},
		'{K_DATA, 8'ha5, 1'b0, T_NCHAR,  9'h0a5},
		'{K_EOP,  8'h00, 1'b0, T_NCHAR,  9'h100},
		'{K_EEP,  8'h00, 1'b0, T_NCHAR,  9'h101},
		'{K_ESC,  8'h00, 1'b0, T_NONE,   9'h000},
		'{K_DATA, 8'h3c, 1'b0, T_TIME,   9'h03c},
		'{K_ESC,  8'h00, 1'b0, T_NONE,   9'h000},
		'{K_EOP,  8'h00, 1'b0, T_ESCERR, 9'h000},
		'{K_DATA, 8'h81, 1'b1, T_NCHAR,  9'h081},
		'{K_FCT,  8'h00, 1'b0, T_FCT,    9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_DATA, 8'h00, 1'b0, T_NCHAR,  9'h000},
		'{K_EOP,  8'h00, 1'b0, T_NCHAR,  9'h100},
		'{K_FCT,  8'h00, 1'b0, T_FCT,    9'h000}
	};

	row_t        exp_q [$];
	int          value_errors = 0;
	int          token_errors = 0;
	int          tokens_expected = 0;
	int          tokens_seen = 0;
	int          cycles = 0;
	logic        prev_odd = 1'b0;
	logic        overflow_seen = 1'b0;
	logic [31:0] rng_state;

	spw_rx_top u_dut (.*);

	always #4 negedge_clk = ~negedge_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Strobe toggles when the data line keeps its value
	task automatic drive_bit(input logic b);
		if (b == rx_din)
			rx_sin = ~rx_sin;
		else
			rx_din = b;
		repeat (BIT_CLOCKS) @(posedge negedge_clk);
		#1;
	endtask

	task automatic send_char(input row_t r);
		logic       flag;
		logic       par;
		logic [7:0] bits;
		int         n;
		flag = (r.kind != K_DATA);
		n    = flag ? 2 : 8;
		case (r.kind)
			K_EOP:   bits = 8'd1;
			K_EEP:   bits = 8'd2;
			K_ESC:   bits = 8'd3;
			K_DATA:  bits = r.payload;
			default: bits = 8'd0;
		endcase
		// Odd count over previous payload, parity and flag
		par = ~(prev_odd ^ flag) ^ r.bad;
		drive_bit(par);
		drive_bit(flag);
		for (int k = 0; k < n; k++)
		begin
			if (k == n - 1 && r.tok != T_NONE)
			begin
				exp_q.push_back(r);
				tokens_expected++;
			end
			// Control code goes MSB first and data byte LSB first
			drive_bit(flag ? bits[n-1-k] : bits[k]);
		end
		prev_odd = ^bits;
	endtask

	// ------------------------------------------------------------------------
	// Token monitor sampled away from the active edge
	// ------------------------------------------------------------------------
	always @(negedge negedge_clk)
	begin : monitor
		tok_e act;
		row_t want;
		act = got_fct ? T_FCT : got_null ? T_NULL : got_nchar ? T_NCHAR :
			got_time_code ? T_TIME : esc_error ? T_ESCERR : T_NONE;
		if (fifo_overflow !== 1'b0 && !overflow_seen)
		begin
			overflow_seen = 1'b1;
			value_errors++;
			$display("FAIL fifo_overflow expected 0x0 actual 0x%h", fifo_overflow);
		end
		if (!rx_resetn)
		begin
			if (act != T_NONE || parity_error === 1'b1)
			begin
				token_errors++;
				$display("Decoder strobe high while reset is asserted");
			end
		end
		else if (act == T_NONE)
		begin
			if (parity_error === 1'b1)
			begin
				token_errors++;
				$display("parity_error raised without any token");
			end
		end
		else if (exp_q.size() == 0)
		begin
			tokens_seen++;
			token_errors++;
			$display("Unexpected %s token while none was expected", act.name());
		end
		else
		begin
			tokens_seen++;
			want = exp_q.pop_front();
			if (act != want.tok)
			begin
				token_errors++;
				$display("Wrong token: expected %s, got %s", want.tok.name(), act.name());
			end
			else if (act == T_NCHAR && nchar_data !== want.val)
			begin
				value_errors++;
				$display("FAIL nchar_data expected 0x%h actual 0x%h", want.val, nchar_data);
			end
			else if (act == T_TIME && time_code !== want.val[7:0])
			begin
				value_errors++;
				$display("FAIL time_code expected 0x%h actual 0x%h", want.val[7:0], time_code);
			end
			if (parity_error !== want.bad)
			begin
				value_errors++;
				$display("FAIL parity_error expected 0x%h actual 0x%h", want.bad, parity_error);
			end
		end
	end

	always @(posedge negedge_clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with %0d tokens outstanding", cycles, exp_q.size());
			$display("Errors: %0d value, %0d token", value_errors, token_errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		rx_resetn   = 1'b1;
		rx_din      = 1'b0;
		rx_sin      = 1'b0;
		rng_state   = 32'd20366;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			rng_state = xorshift(rng_state);
			rows[RAND_FIRST + i].payload = rng_state[7:0];
			rows[RAND_FIRST + i].val     = {1'b0, rng_state[7:0]};
		end
		#1 rx_resetn = 1'b0;
		repeat (4) @(posedge negedge_clk);
		#1 rx_resetn = 1'b1;
		@(posedge negedge_clk);
		#1;
		for (int i = 0; i < NUM_ROWS; i++)
			send_char(rows[i]);
		while (exp_q.size() != 0)
			@(posedge negedge_clk);
		// Room for any stray token
		repeat (20) @(posedge negedge_clk);
		if (tokens_seen != tokens_expected)
		begin
			token_errors++;
			$display("Received %0d tokens but expected %0d", tokens_seen, tokens_expected);
		end
		$display("Errors: %0d value, %0d token", value_errors, token_errors);
		if (value_errors == 0 && token_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* spw_rx_properties.sv */
`default_nettype none

module spw_rx_properties
(
	input wire logic       negedge_clk,
	input wire logic       rx_resetn,
	input wire logic       got_fct,
	input wire logic       got_null,
	input wire logic       got_nchar,
	input wire logic [8:0] nchar_data,
	input wire logic       got_time_code,
	input wire logic       parity_error,
	input wire logic       esc_error,
	input wire logic       fifo_overflow
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [4:0] tok_strobes;

	assign tok_strobes = {got_fct, got_null, got_nchar, got_time_code, esc_error};

	strobes_exclusive: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		$onehot0(tok_strobes))
		else $error("More than one token strobe high");

	// Everything quiet while reset holds
	quiet_in_reset: assert property (@(posedge negedge_clk)
		!rx_resetn |-> (tok_strobes == '0 && !parity_error && !fifo_overflow))
		else $error("Decoder output high during reset");

	nchar_marker: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		(got_nchar && nchar_data[8]) |-> (nchar_data[7:1] == '0))
		else $error("nchar_data bit 8 set for a value other than EOP or EEP");

endmodule

bind spw_rx_top spw_rx_properties u_props (.*);

`default_nettype wire

/* spw_rx_top.sv */
`default_nettype none

module spw_rx_top
(
	input  wire logic       negedge_clk,
	input  wire logic       rx_resetn,
	input  wire logic       rx_din,
	input  wire logic       rx_sin,
	output wire logic       got_fct,
	output wire logic       got_null,
	output wire logic       got_nchar,
	output wire logic [8:0] nchar_data,
	output wire logic       got_time_code,
	output wire logic [7:0] time_code,
	output wire logic       parity_error,
	output wire logic       esc_error,
	output wire logic       fifo_overflow
);

	wire logic                   char_valid;
	wire spw_rx_pkg::char_word_t char_word;
	wire logic                   tok_valid;
	wire spw_rx_pkg::char_word_t tok_word;

	// Data-strobe lines to framed characters
	ds_char_framer u_framer
	(
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.char_valid  (char_valid),
		.char_word   (char_word)
	);

	char_fifo u_fifo
	(
		.negedge_clk   (negedge_clk),
		.rx_resetn     (rx_resetn),
		.char_valid    (char_valid),
		.char_word     (char_word),
		.tok_valid     (tok_valid),
		.tok_word      (tok_word),
		.fifo_overflow (fifo_overflow)
	);

	// Parity check and token decode
	token_decoder u_decoder
	(
		.negedge_clk   (negedge_clk),
		.rx_resetn     (rx_resetn),
		.tok_valid     (tok_valid),
		.tok_word      (tok_word),
		.got_fct       (got_fct),
		.got_null      (got_null),
		.got_nchar     (got_nchar),
		.nchar_data    (nchar_data),
		.got_time_code (got_time_code),
		.time_code     (time_code),
		.parity_error  (parity_error),
		.esc_error     (esc_error)
	);

endmodule

`default_nettype wire

/* token_decoder.sv */
`default_nettype none

module token_decoder
(
	input  wire logic                   negedge_clk,
	input  wire logic                   rx_resetn,
	input  wire logic                   tok_valid,
	input  wire spw_rx_pkg::char_word_t tok_word,
	output logic                        got_fct,
	output logic                        got_null,
	output logic                        got_nchar,
	output logic [8:0]                  nchar_data,
	output logic                        got_time_code,
	output logic [7:0]                  time_code,
	output logic                        parity_error,
	output logic                        esc_error
);

	logic esc_pending;
	logic has_prev;
	logic parity_ok;

	// Payload bits of the previous character, control codes zero extended
	logic [spw_rx_pkg::DATA_BITS-1:0] prev_payload;
	logic [spw_rx_pkg::CTRL_BITS-1:0] code;
	logic                             is_ctrl;

	assign is_ctrl = tok_word.ctrl_view.flag;
	assign code    = tok_word.ctrl_view.code;

	// --------------------------------------------------------------------------
	// Odd parity across the character boundary
	// --------------------------------------------------------------------------

	assign parity_ok = ^{prev_payload, tok_word.data_view.parity, tok_word.data_view.flag};

	// --------------------------------------------------------------------------
	// Token decode
	// --------------------------------------------------------------------------

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			got_fct       <= 1'b0;
			got_null      <= 1'b0;
			got_nchar     <= 1'b0;
			got_time_code <= 1'b0;
			parity_error  <= 1'b0;
			esc_error     <= 1'b0;
			esc_pending   <= 1'b0;
			has_prev      <= 1'b0;
		end
		else
		begin
			got_fct       <= 1'b0;
			got_null      <= 1'b0;
			got_nchar     <= 1'b0;
			got_time_code <= 1'b0;
			parity_error  <= 1'b0;
			esc_error     <= 1'b0;
			if (tok_valid)
			begin
				// First character after reset has nothing to check against
				has_prev     <= 1'b1;
				parity_error <= has_prev & ~parity_ok;
				if (is_ctrl)
				begin
					if (esc_pending)
					begin
						esc_pending <= 1'b0;
						if (code == spw_rx_pkg::CODE_FCT)
							got_null <= 1'b1;
						else
							esc_error <= 1'b1;
					end
					else
					begin
						case (code)
							spw_rx_pkg::CODE_FCT: got_fct     <= 1'b1;
							spw_rx_pkg::CODE_ESC: esc_pending <= 1'b1;
							default:              got_nchar   <= 1'b1;
						endcase
					end
				end
				else if (esc_pending)
				begin
					esc_pending   <= 1'b0;
					got_time_code <= 1'b1;
				end
				else
					got_nchar <= 1'b1;
			end
		end
	end

	// Values that travel with the strobes
	always_ff @(posedge negedge_clk)
	begin
		if (tok_valid)
		begin
			if (is_ctrl)
			begin
				prev_payload <= {{(spw_rx_pkg::DATA_BITS - spw_rx_pkg::CTRL_BITS){1'b0}}, code};
				if (code == spw_rx_pkg::CODE_EOP)
					nchar_data <= spw_rx_pkg::NCHAR_EOP;
				else if (code == spw_rx_pkg::CODE_EEP)
					nchar_data <= spw_rx_pkg::NCHAR_EEP;
			end
			else
			begin
				prev_payload <= tok_word.data_view.data;
				nchar_data   <= {1'b0, tok_word.data_view.data};
				time_code    <= tok_word.data_view.data;
			end
		end
	end

endmodule

`default_nettype wire

/* char_fifo.sv */
`default_nettype none

module char_fifo
(
	input  wire logic                   negedge_clk,
	input  wire logic                   rx_resetn,
	input  wire logic                   char_valid,
	input  wire spw_rx_pkg::char_word_t char_word,
	output logic                        tok_valid,
	output spw_rx_pkg::char_word_t      tok_word,
	output logic                        fifo_overflow
);

	spw_rx_pkg::char_word_t mem [spw_rx_pkg::FIFO_DEPTH];

	logic [spw_rx_pkg::FIFO_AW-1:0] wr_ptr;
	logic [spw_rx_pkg::FIFO_AW-1:0] rd_ptr;
	logic [spw_rx_pkg::FIFO_AW:0]   count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == (spw_rx_pkg::FIFO_AW + 1)'(spw_rx_pkg::FIFO_DEPTH));
	assign push = char_valid & ~full;

	// Drains one entry per cycle, the decoder never stalls
	assign pop       = (count != '0);
	assign tok_valid = pop;
	assign tok_word  = mem[rd_ptr];

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			fifo_overflow <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky until reset
			if (char_valid && full)
				fifo_overflow <= 1'b1;
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (push)
			mem[wr_ptr] <= char_word;
	end

endmodule

`default_nettype wire

/* ds_char_framer.sv */
`default_nettype none

module ds_char_framer
(
	input  wire logic              negedge_clk,
	input  wire logic              rx_resetn,
	input  wire logic              rx_din,
	input  wire logic              rx_sin,
	output logic                   char_valid,
	output spw_rx_pkg::char_word_t char_word
);

	// Synchronizer stages and the previously seen pair
	logic din_meta;
	logic din_sync;
	logic din_last;
	logic sin_meta;
	logic sin_sync;
	logic sin_last;

	logic bit_take;
	logic bit_val;
	logic last_bit;

	// Position inside the current character, 0 is parity, 1 is flag
	logic [3:0] bit_cnt;
	logic       flag_q;
	logic       par_q;
	logic [spw_rx_pkg::DATA_BITS-1:0] shift_q;

	spw_rx_pkg::char_word_t next_word;

	// --------------------------------------------------------------------------
	// Line synchronization and bit recovery
	// --------------------------------------------------------------------------

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			din_meta <= 1'b0;
			din_sync <= 1'b0;
			din_last <= 1'b0;
			sin_meta <= 1'b0;
			sin_sync <= 1'b0;
			sin_last <= 1'b0;
		end
		else
		begin
			din_meta <= rx_din;
			din_sync <= din_meta;
			din_last <= din_sync;
			sin_meta <= rx_sin;
			sin_sync <= sin_meta;
			sin_last <= sin_sync;
		end
	end

	// One line toggles per bit period, any change marks a new bit
	assign bit_take = (din_sync ^ din_last) | (sin_sync ^ sin_last);
	assign bit_val  = din_sync;

	// --------------------------------------------------------------------------
	// Character framing
	// --------------------------------------------------------------------------

	// Final bit index depends on the flag
	always_comb
	begin
		if (flag_q)
			last_bit = (bit_cnt == 4'(spw_rx_pkg::CTRL_BITS + 1));
		else
			last_bit = (bit_cnt == 4'(spw_rx_pkg::DATA_BITS + 1));
	end

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_cnt    <= '0;
			flag_q     <= 1'b0;
			char_valid <= 1'b0;
		end
		else
		begin
			char_valid <= 1'b0;
			if (bit_take)
			begin
				if (bit_cnt == 4'd1)
					flag_q <= bit_val;
				if (last_bit)
				begin
					bit_cnt    <= '0;
					char_valid <= 1'b1;
				end
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// Word as it stands once the current bit is the final one
	always_comb
	begin
		next_word = '0;
		if (flag_q)
		begin
			next_word.ctrl_view.parity = par_q;
			next_word.ctrl_view.flag   = 1'b1;
			next_word.ctrl_view.code   = {shift_q[spw_rx_pkg::DATA_BITS-1], bit_val};
		end
		else
		begin
			next_word.data_view.parity = par_q;
			next_word.data_view.flag   = 1'b0;
			next_word.data_view.data   = {bit_val, shift_q[spw_rx_pkg::DATA_BITS-1:1]};
		end
	end

	// Payload shifts in from the top
	always_ff @(posedge negedge_clk)
	begin
		if (bit_take)
		begin
			if (bit_cnt == 4'd0)
				par_q <= bit_val;
			else if (bit_cnt != 4'd1)
				shift_q <= {bit_val, shift_q[spw_rx_pkg::DATA_BITS-1:1]};
			if (last_bit)
				char_word <= next_word;
		end
	end

endmodule

`default_nettype wire

/* spw_rx_pkg.sv */
`default_nettype none

package spw_rx_pkg;

	// --------------------------------------------------------------------------
	// Character geometry
	// --------------------------------------------------------------------------

	// Parity and flag, then the payload
	localparam int CHAR_W    = 10;
	localparam int DATA_BITS = 8;
	localparam int CTRL_BITS = 2;

	// Control codes in line order, first received payload bit in the MSB
	localparam logic [CTRL_BITS-1:0] CODE_FCT = 2'd0;
	localparam logic [CTRL_BITS-1:0] CODE_EOP = 2'd1;
	localparam logic [CTRL_BITS-1:0] CODE_EEP = 2'd2;
	localparam logic [CTRL_BITS-1:0] CODE_ESC = 2'd3;

	// Receive buffer
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW    = 2;

	// N-Char values for the packet markers, a data byte has bit 8 clear
	localparam logic [8:0] NCHAR_EOP = 9'h100;
	localparam logic [8:0] NCHAR_EEP = 9'h101;

	// --------------------------------------------------------------------------
	// Received character word
	// --------------------------------------------------------------------------

	// Flag set selects the control view
	// Data bytes arrive LSB first, so the first payload bit ends up in bit 0
	typedef union packed
	{
		struct packed
		{
			logic                 parity;
			logic                 flag;
			logic [DATA_BITS-1:0] data;
		} data_view;

		struct packed
		{
			logic                              parity;
			logic                              flag;
			logic [CTRL_BITS-1:0]              code;
			logic [CHAR_W-2-CTRL_BITS-1:0]     unused;
		} ctrl_view;
	} char_word_t;

	// Unused control bits are always zero

endpackage

`default_nettype wire
